// ==== design/innerbus_config.svh ====
//==========================================================================
// address map, memory size and timing knobs of the inner bus
// windows must not overlap and each mask must be 2^n - 1
// MEM_WAIT_CYCLES may be 0, MTIME_TICK_DIV must be 1 or more
//==========================================================================
`ifndef INNERBUS_CONFIG_SVH
`define INNERBUS_CONFIG_SVH

// slave windows, base and size mask
`define CLINT_BASE          64'h0000_0000_0200_0000
`define CLINT_MASK          64'h0000_0000_00FF_FFFF
`define PLIC_BASE           64'h0000_0000_0300_0000
`define PLIC_MASK           64'h0000_0000_00FF_FFFF
`define PERIP_BASE          64'h0000_0000_2000_0000
`define PERIP_MASK          64'h0000_0000_1FFF_FFFF
`define SYSBUS_BASE         64'h0000_0000_4000_0000
`define SYSBUS_MASK         64'h0000_0000_3FFF_FFFF
`define MEM_BASE            64'h0000_0000_8000_0000
`define MEM_MASK            64'h0000_0000_7FFF_FFFF

// memory slave
`define MEM_IDX_W           8
`define MEM_WAIT_CYCLES     2

// clint
`define MTIME_TICK_DIV      4
`define CLINT_MSIP_OFS      24'h00_0000
`define CLINT_MTIMECMP_OFS  24'h00_4000
`define CLINT_MTIME_OFS     24'h00_BFF8

`endif

// ==== design/innerbus_pkg.sv ====
//==========================================================================
// shared bus types, memory controller states and byte merge helper
// all bus lanes are 64 bit with one strobe bit per byte
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

package innerbus_pkg;

	typedef logic [63:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0] strb_t;
	typedef logic [`MEM_IDX_W-1:0] mem_idx_t;

	// memory slave FSM
	typedef enum logic [1:0] {IDLE, WAIT, RESP} mem_state_t;

	// replace the strobed byte lanes of old_val
	function automatic data_t strb_merge(data_t old_val, data_t new_val, strb_t strb);
		data_t res;
		res = old_val;
		for (int b = 0; b < $bits(strb_t); b++) begin
			if (strb[b]) begin
				res[b*8 +: 8] = new_val[b*8 +: 8];
			end
		end
		return res;
	endfunction

endpackage

`default_nettype wire

// ==== design/innerbus_crossbar.sv ====
//==========================================================================
// fully combinational 3 master to 5 slave crossbar
// fixed priority dm > ifu > lsu with no locking, a higher master may
// take the path over mid transfer; unmapped addresses get no response
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

module innerbus_crossbar import innerbus_pkg::*; (
	// masters
	input  logic  dm_req_valid,
	input  addr_t dm_addr,
	input  data_t dm_data_w,
	input  strb_t dm_wstrb,
	input  logic  dm_wen,
	output logic  dm_rsp_valid,
	output data_t dm_data_r,

	input  logic  ifu_req_valid,
	input  addr_t ifu_addr,
	input  data_t ifu_data_w,
	input  strb_t ifu_wstrb,
	input  logic  ifu_wen,
	output logic  ifu_rsp_valid,
	output data_t ifu_data_r,

	input  logic  lsu_req_valid,
	input  addr_t lsu_addr,
	input  data_t lsu_data_w,
	input  strb_t lsu_wstrb,
	input  logic  lsu_wen,
	output logic  lsu_rsp_valid,
	output data_t lsu_data_r,

	// slaves
	output logic  clint_req_valid,
	output addr_t clint_addr,
	output data_t clint_data_w,
	output strb_t clint_wstrb,
	output logic  clint_wen,
	input  logic  clint_rsp_valid,
	input  data_t clint_data_r,

	output logic  plic_req_valid,
	output addr_t plic_addr,
	output data_t plic_data_w,
	output strb_t plic_wstrb,
	output logic  plic_wen,
	input  logic  plic_rsp_valid,
	input  data_t plic_data_r,

	output logic  sysbus_req_valid,
	output addr_t sysbus_addr,
	output data_t sysbus_data_w,
	output strb_t sysbus_wstrb,
	output logic  sysbus_wen,
	input  logic  sysbus_rsp_valid,
	input  data_t sysbus_data_r,

	output logic  perip_req_valid,
	output addr_t perip_addr,
	output data_t perip_data_w,
	output strb_t perip_wstrb,
	output logic  perip_wen,
	input  logic  perip_rsp_valid,
	input  data_t perip_data_r,

	output logic  mem_req_valid,
	output addr_t mem_addr,
	output data_t mem_data_w,
	output strb_t mem_wstrb,
	output logic  mem_wen,
	input  logic  mem_rsp_valid,
	input  data_t mem_data_r
);

	logic dm_grant;
	logic ifu_grant;
	logic lsu_grant;
	logic any_grant;
	addr_t arb_addr;
	data_t arb_data_w;
	strb_t arb_wstrb;
	logic arb_wen;
	logic clint_sel;
	logic plic_sel;
	logic sysbus_sel;
	logic perip_sel;
	logic mem_sel;
	logic rsp_any;
	data_t rsp_data;

	// fixed priority grant
	assign dm_grant = dm_req_valid;
	assign ifu_grant = ~dm_req_valid & ifu_req_valid;
	assign lsu_grant = ~dm_req_valid & ~ifu_req_valid & lsu_req_valid;
	assign any_grant = dm_grant | ifu_grant | lsu_grant;

	// request fields of the winner, zero when idle
	always_comb begin
		arb_addr = '0;
		arb_data_w = '0;
		arb_wstrb = '0;
		arb_wen = 1'b0;
		if (dm_grant) begin
			arb_addr = dm_addr;
			arb_data_w = dm_data_w;
			arb_wstrb = dm_wstrb;
			arb_wen = dm_wen;
		end else if (ifu_grant) begin
			arb_addr = ifu_addr;
			arb_data_w = ifu_data_w;
			arb_wstrb = ifu_wstrb;
			arb_wen = ifu_wen;
		end else if (lsu_grant) begin
			arb_addr = lsu_addr;
			arb_data_w = lsu_data_w;
			arb_wstrb = lsu_wstrb;
			arb_wen = lsu_wen;
		end
	end

	// window decode, upper 32 bits must be zero to hit
	assign clint_sel = any_grant & ((arb_addr | `CLINT_MASK) == (`CLINT_BASE | `CLINT_MASK));
	assign plic_sel = any_grant & ((arb_addr | `PLIC_MASK) == (`PLIC_BASE | `PLIC_MASK));
	assign sysbus_sel = any_grant & ((arb_addr | `SYSBUS_MASK) == (`SYSBUS_BASE | `SYSBUS_MASK));
	assign perip_sel = any_grant & ((arb_addr | `PERIP_MASK) == (`PERIP_BASE | `PERIP_MASK));
	assign mem_sel = any_grant & ((arb_addr | `MEM_MASK) == (`MEM_BASE | `MEM_MASK));

	// only the selected slave sees a nonzero request
	assign clint_req_valid = clint_sel;
	assign clint_addr = clint_sel ? arb_addr : '0;
	assign clint_data_w = clint_sel ? arb_data_w : '0;
	assign clint_wstrb = clint_sel ? arb_wstrb : '0;
	assign clint_wen = clint_sel & arb_wen;

	assign plic_req_valid = plic_sel;
	assign plic_addr = plic_sel ? arb_addr : '0;
	assign plic_data_w = plic_sel ? arb_data_w : '0;
	assign plic_wstrb = plic_sel ? arb_wstrb : '0;
	assign plic_wen = plic_sel & arb_wen;

	assign sysbus_req_valid = sysbus_sel;
	assign sysbus_addr = sysbus_sel ? arb_addr : '0;
	assign sysbus_data_w = sysbus_sel ? arb_data_w : '0;
	assign sysbus_wstrb = sysbus_sel ? arb_wstrb : '0;
	assign sysbus_wen = sysbus_sel & arb_wen;

	assign perip_req_valid = perip_sel;
	assign perip_addr = perip_sel ? arb_addr : '0;
	assign perip_data_w = perip_sel ? arb_data_w : '0;
	assign perip_wstrb = perip_sel ? arb_wstrb : '0;
	assign perip_wen = perip_sel & arb_wen;

	assign mem_req_valid = mem_sel;
	assign mem_addr = mem_sel ? arb_addr : '0;
	assign mem_data_w = mem_sel ? arb_data_w : '0;
	assign mem_wstrb = mem_sel ? arb_wstrb : '0;
	assign mem_wen = mem_sel & arb_wen;

	// response of the selected slave only
	assign rsp_any = (clint_sel & clint_rsp_valid) | (plic_sel & plic_rsp_valid)
		| (sysbus_sel & sysbus_rsp_valid) | (perip_sel & perip_rsp_valid)
		| (mem_sel & mem_rsp_valid);

	assign rsp_data = ({64{clint_sel & clint_rsp_valid}} & clint_data_r)
		| ({64{plic_sel & plic_rsp_valid}} & plic_data_r)
		| ({64{sysbus_sel & sysbus_rsp_valid}} & sysbus_data_r)
		| ({64{perip_sel & perip_rsp_valid}} & perip_data_r)
		| ({64{mem_sel & mem_rsp_valid}} & mem_data_r);

	// steer back to the granted master
	assign dm_rsp_valid = dm_grant & rsp_any;
	assign ifu_rsp_valid = ifu_grant & rsp_any;
	assign lsu_rsp_valid = lsu_grant & rsp_any;
	assign dm_data_r = dm_grant ? rsp_data : '0;
	assign ifu_data_r = ifu_grant ? rsp_data : '0;
	assign lsu_data_r = lsu_grant ? rsp_data : '0;

endmodule

`default_nettype wire

// ==== design/clint_mtime.sv ====
//==========================================================================
// free running 64 bit mtime, one increment every MTIME_TICK_DIV clocks
// a software write wins over the tick in the same cycle
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

module clint_mtime import innerbus_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  wr_en,
	input  data_t wr_data,
	input  strb_t wr_strb,
	output data_t mtime
);

	localparam int DIV = `MTIME_TICK_DIV;
	localparam int PRE_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [PRE_W-1:0] pre_cnt;
	logic tick;

	// last prescaler step
	assign tick = (pre_cnt == PRE_W'(DIV - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_cnt <= '0;
			mtime <= '0;
		end else if (wr_en) begin
			// new time base, count a full period again
			pre_cnt <= '0;
			mtime <= strb_merge(mtime, wr_data, wr_strb);
		end else if (tick) begin
			pre_cnt <= '0;
			mtime <= mtime + 64'd1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/clint.sv ====
//==========================================================================
// single hart CLINT with msip, mtimecmp and mtime
// only addr[23:0] is decoded, other offsets read zero and drop writes
// one response cycle right after each accepted request
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

module clint import innerbus_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  req_valid,
	input  addr_t addr,
	input  data_t data_w,
	input  strb_t wstrb,
	input  logic  wen,
	output logic  rsp_valid,
	output data_t data_r,
	output logic  msip_irq,
	output logic  mtip_irq
);

	logic [23:0] ofs;
	logic accept;
	logic hit_msip;
	logic hit_cmp;
	logic hit_time;
	logic msip;
	data_t mtimecmp;
	data_t mtime;
	data_t rd_data;

	assign ofs = addr[23:0];
	// held request is not taken again in its response cycle
	assign accept = req_valid & ~rsp_valid;

	assign hit_msip = (ofs == `CLINT_MSIP_OFS);
	assign hit_cmp = (ofs == `CLINT_MTIMECMP_OFS);
	assign hit_time = (ofs == `CLINT_MTIME_OFS);

	clint_mtime u_mtime (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (accept & wen & hit_time),
		.wr_data (data_w),
		.wr_strb (wstrb),
		.mtime   (mtime)
	);

	// read mux
	always_comb begin
		rd_data = '0;
		if (hit_msip) begin
			rd_data = {63'd0, msip};
		end else if (hit_cmp) begin
			rd_data = mtimecmp;
		end else if (hit_time) begin
			rd_data = mtime;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
			msip <= 1'b0;
			// all ones keeps mtip low out of reset
			mtimecmp <= '1;
		end else begin
			rsp_valid <= accept;
			if (accept & wen & hit_msip & wstrb[0]) begin
				msip <= data_w[0];
			end
			if (accept & wen & hit_cmp) begin
				mtimecmp <= strb_merge(mtimecmp, data_w, wstrb);
			end
		end
	end

	// writes return zero
	always_ff @(posedge clk) begin
		if (accept) begin
			data_r <= wen ? '0 : rd_data;
		end
	end

	assign msip_irq = msip;
	assign mtip_irq = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// ==== design/mem_ctrl_fsm.sv ====
//==========================================================================
// memory bus slave, MEM_WAIT_CYCLES wait states then one response cycle
// response arrives MEM_WAIT_CYCLES + 1 edges after accept
// address bits above the word index alias onto the array
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

module mem_ctrl_fsm import innerbus_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     req_valid,
	input  addr_t    addr,
	input  data_t    data_w,
	input  strb_t    wstrb,
	input  logic     wen,
	output logic     rsp_valid,
	output data_t    data_r,
	output logic     arr_en,
	output logic     arr_wen,
	output mem_idx_t arr_idx,
	output data_t    arr_data_w,
	output strb_t    arr_wstrb,
	input  data_t    arr_data_r
);

	localparam int WAIT_N = `MEM_WAIT_CYCLES;
	localparam int CNT_W = (WAIT_N > 1) ? $clog2(WAIT_N) : 1;

	mem_state_t state;
	logic [CNT_W-1:0] wait_cnt;
	logic accept;
	logic wr_q;

	// idle and not in the response cycle of the previous request
	assign accept = (state == IDLE) & req_valid & ~rsp_valid;

	// array access fires straight from the live request
	assign arr_en = accept;
	assign arr_wen = accept & wen;
	assign arr_idx = addr[`MEM_IDX_W+2:3];
	assign arr_data_w = data_w;
	assign arr_wstrb = wstrb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			wait_cnt <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						wait_cnt <= CNT_W'(WAIT_N - 1);
						if (WAIT_N == 0) begin
							state <= RESP;
						end else begin
							state <= WAIT;
						end
					end
				end
				WAIT: begin
					if (wait_cnt == '0) begin
						state <= RESP;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				RESP: begin
					rsp_valid <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// direction of the access, then the captured read word
	always_ff @(posedge clk) begin
		if (accept) begin
			wr_q <= wen;
		end
		if (state == RESP) begin
			data_r <= wr_q ? '0 : arr_data_r;
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_array.sv ====
//==========================================================================
// single port word store, byte strobed write, registered read
// read returns the word before a same cycle write, contents start unknown
//==========================================================================
`default_nettype none

module mem_array import innerbus_pkg::*; (
	input  logic     clk,
	input  logic     en,
	input  logic     wen,
	input  mem_idx_t idx,
	input  data_t    data_w,
	input  strb_t    wstrb,
	output data_t    data_r
);

	localparam int DEPTH = 2 ** $bits(mem_idx_t);

	data_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (en) begin
			if (wen) begin
				// per lane write enables
				for (int b = 0; b < $bits(strb_t); b++) begin
					if (wstrb[b]) begin
						mem[idx][b*8 +: 8] <= data_w[b*8 +: 8];
					end
				end
			end
			data_r <= mem[idx];
		end
	end

endmodule

`default_nettype wire

// ==== design/innerbus_top.sv ====
//==========================================================================
// inner bus subsystem with CLINT and memory slave inside
// plic, sysbus and perip ports go to external slaves that must follow
// the same one pulse response handshake
//==========================================================================
`default_nettype none

module innerbus_top import innerbus_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,

	// masters
	input  logic  dm_req_valid,
	input  addr_t dm_addr,
	input  data_t dm_data_w,
	input  strb_t dm_wstrb,
	input  logic  dm_wen,
	output logic  dm_rsp_valid,
	output data_t dm_data_r,

	input  logic  ifu_req_valid,
	input  addr_t ifu_addr,
	input  data_t ifu_data_w,
	input  strb_t ifu_wstrb,
	input  logic  ifu_wen,
	output logic  ifu_rsp_valid,
	output data_t ifu_data_r,

	input  logic  lsu_req_valid,
	input  addr_t lsu_addr,
	input  data_t lsu_data_w,
	input  strb_t lsu_wstrb,
	input  logic  lsu_wen,
	output logic  lsu_rsp_valid,
	output data_t lsu_data_r,

	// external slaves
	output logic  plic_req_valid,
	output addr_t plic_addr,
	output data_t plic_data_w,
	output strb_t plic_wstrb,
	output logic  plic_wen,
	input  logic  plic_rsp_valid,
	input  data_t plic_data_r,

	output logic  sysbus_req_valid,
	output addr_t sysbus_addr,
	output data_t sysbus_data_w,
	output strb_t sysbus_wstrb,
	output logic  sysbus_wen,
	input  logic  sysbus_rsp_valid,
	input  data_t sysbus_data_r,

	output logic  perip_req_valid,
	output addr_t perip_addr,
	output data_t perip_data_w,
	output strb_t perip_wstrb,
	output logic  perip_wen,
	input  logic  perip_rsp_valid,
	input  data_t perip_data_r,

	output logic  msip_irq,
	output logic  mtip_irq
);

	// clint port
	logic clint_req_valid;
	addr_t clint_addr;
	data_t clint_data_w;
	strb_t clint_wstrb;
	logic clint_wen;
	logic clint_rsp_valid;
	data_t clint_data_r;

	// memory port
	logic mem_req_valid;
	addr_t mem_addr;
	data_t mem_data_w;
	strb_t mem_wstrb;
	logic mem_wen;
	logic mem_rsp_valid;
	data_t mem_data_r;

	// controller to array
	logic arr_en;
	logic arr_wen;
	mem_idx_t arr_idx;
	data_t arr_data_w;
	strb_t arr_wstrb;
	data_t arr_data_r;

	// port names match the nets above one to one
	innerbus_crossbar u_xbar (.*);

	clint u_clint (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (clint_req_valid),
		.addr      (clint_addr),
		.data_w    (clint_data_w),
		.wstrb     (clint_wstrb),
		.wen       (clint_wen),
		.rsp_valid (clint_rsp_valid),
		.data_r    (clint_data_r),
		.msip_irq  (msip_irq),
		.mtip_irq  (mtip_irq)
	);

	mem_ctrl_fsm u_mem_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (mem_req_valid),
		.addr       (mem_addr),
		.data_w     (mem_data_w),
		.wstrb      (mem_wstrb),
		.wen        (mem_wen),
		.rsp_valid  (mem_rsp_valid),
		.data_r     (mem_data_r),
		.arr_en     (arr_en),
		.arr_wen    (arr_wen),
		.arr_idx    (arr_idx),
		.arr_data_w (arr_data_w),
		.arr_wstrb  (arr_wstrb),
		.arr_data_r (arr_data_r)
	);

	mem_array u_mem_array (
		.clk    (clk),
		.en     (arr_en),
		.wen    (arr_wen),
		.idx    (arr_idx),
		.data_w (arr_data_w),
		.wstrb  (arr_wstrb),
		.data_r (arr_data_r)
	);

endmodule

`default_nettype wire

// ==== tests/innerbus_tb.sv ====
//==========================================================================
// directed testbench for innerbus_top, plic/sysbus/perip answered by
// behavioral slaves that return addr ^ key one cycle after a request
// memory words are written in full before any partial strobe write
//==========================================================================
`default_nettype none

`include "innerbus_config.svh"

// external slave, one response pulse after each accepted request
module ext_slave_model import innerbus_pkg::*; #(
	parameter data_t KEY = '0
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  req_valid,
	input  addr_t addr,
	input  logic  wen,
	output logic  rsp_valid,
	output data_t data_r,
	output addr_t seen_addr
);
	timeunit 1ns;
	timeprecision 1ps;

	logic rsp_q = 1'b0;
	data_t data_q = '0;
	addr_t seen_q = '0;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_q <= 1'b0;
			data_q <= '0;
		end else begin
			// held request is ignored in the response cycle
			rsp_q <= req_valid & ~rsp_q;
			if (req_valid & ~rsp_q) begin
				data_q <= wen ? '0 : (addr ^ KEY);
				seen_q <= addr;
			end
		end
	end

	assign rsp_valid = rsp_q;
	assign data_r = data_q;
	assign seen_addr = seen_q;
endmodule

module innerbus_tb import innerbus_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int dm_id = 0;
	localparam int ifu_id = 1;
	localparam int lsu_id = 2;
	localparam int rsp_limit = 64;
	localparam int n_txn = 47;
	localparam int watchdog_cycles = n_txn * 64 + 1000;
	localparam int mem_words = 2 ** `MEM_IDX_W;
	localparam data_t plic_key = 64'h5A5A_0000_0000_A5A5;
	localparam data_t sysbus_key = 64'hC3C3_1111_2222_3C3C;
	localparam data_t perip_key = 64'h0F0F_F0F0_0F0F_F0F0;

	logic clk;
	logic arst_n;
	logic dm_req_valid, ifu_req_valid, lsu_req_valid;
	addr_t dm_addr, ifu_addr, lsu_addr;
	data_t dm_data_w, ifu_data_w, lsu_data_w;
	strb_t dm_wstrb, ifu_wstrb, lsu_wstrb;
	logic dm_wen, ifu_wen, lsu_wen;
	logic dm_rsp_valid, ifu_rsp_valid, lsu_rsp_valid;
	data_t dm_data_r, ifu_data_r, lsu_data_r;
	logic plic_req_valid, sysbus_req_valid, perip_req_valid;
	addr_t plic_addr, sysbus_addr, perip_addr;
	data_t plic_data_w, sysbus_data_w, perip_data_w;
	strb_t plic_wstrb, sysbus_wstrb, perip_wstrb;
	logic plic_wen, sysbus_wen, perip_wen;
	logic plic_rsp_valid, sysbus_rsp_valid, perip_rsp_valid;
	data_t plic_data_r, sysbus_data_r, perip_data_r;
	addr_t plic_seen, sysbus_seen, perip_seen;
	logic msip_irq;
	logic mtip_irq;

	int seed = 58;
	int mismatch_cnt = 0;
	int failure_cnt = 0;
	int done_cnt;
	// req_valid cycles per slave: clint, plic, sysbus, perip, mem
	int req_cnt [5] = '{0, 0, 0, 0, 0};
	int req_snap [5];
	string slave_name [5] = '{"clint", "plic", "sysbus", "perip", "mem"};
	data_t mem_model [mem_words];

	innerbus_top UUT (.*);

	ext_slave_model #(.KEY(plic_key)) u_plic (
		.clk(clk), .arst_n(arst_n), .req_valid(plic_req_valid), .addr(plic_addr),
		.wen(plic_wen), .rsp_valid(plic_rsp_valid), .data_r(plic_data_r),
		.seen_addr(plic_seen)
	);
	ext_slave_model #(.KEY(sysbus_key)) u_sysbus (
		.clk(clk), .arst_n(arst_n), .req_valid(sysbus_req_valid), .addr(sysbus_addr),
		.wen(sysbus_wen), .rsp_valid(sysbus_rsp_valid), .data_r(sysbus_data_r),
		.seen_addr(sysbus_seen)
	);
	ext_slave_model #(.KEY(perip_key)) u_perip (
		.clk(clk), .arst_n(arst_n), .req_valid(perip_req_valid), .addr(perip_addr),
		.wen(perip_wen), .rsp_valid(perip_rsp_valid), .data_r(perip_data_r),
		.seen_addr(perip_seen)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_data(input data_t got, input data_t exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		failure_cnt++;
	endtask

	// unselected slave port must carry all zero fields
	task automatic check_quiet_port(input logic v, input addr_t a, input data_t wd,
		input strb_t st, input logic we, input string name);
		if (!v) begin
			check_addr(a, '0, {name, "_addr"});
			check_data(wd, '0, {name, "_data_w"});
			check_data(data_t'(st), '0, {name, "_wstrb"});
			check_bit(we, 1'b0, {name, "_wen"});
		end
	endtask

	// request counting and the no response while not selected rule
	always @(negedge clk) begin
		if (arst_n) begin
			if (UUT.clint_req_valid) req_cnt[0]++;
			if (plic_req_valid) req_cnt[1]++;
			if (sysbus_req_valid) req_cnt[2]++;
			if (perip_req_valid) req_cnt[3]++;
			if (UUT.mem_req_valid) req_cnt[4]++;
			if (dm_req_valid) begin
				check_bit(ifu_rsp_valid, 1'b0, "ifu_rsp_valid while dm holds the bus");
				check_bit(lsu_rsp_valid, 1'b0, "lsu_rsp_valid while dm holds the bus");
			end else if (ifu_req_valid) begin
				check_bit(lsu_rsp_valid, 1'b0, "lsu_rsp_valid while ifu holds the bus");
			end
			check_quiet_port(plic_req_valid, plic_addr, plic_data_w, plic_wstrb,
				plic_wen, "plic");
			check_quiet_port(sysbus_req_valid, sysbus_addr, sysbus_data_w, sysbus_wstrb,
				sysbus_wen, "sysbus");
			check_quiet_port(perip_req_valid, perip_addr, perip_data_w, perip_wstrb,
				perip_wen, "perip");
		end
	end

	function automatic string master_name(input int m);
		case (m)
			dm_id: return "dm";
			ifu_id: return "ifu";
			default: return "lsu";
		endcase
	endfunction

	function automatic logic rsp_of(input int m);
		case (m)
			dm_id: return dm_rsp_valid;
			ifu_id: return ifu_rsp_valid;
			default: return lsu_rsp_valid;
		endcase
	endfunction

	function automatic data_t rdata_of(input int m);
		case (m)
			dm_id: return dm_data_r;
			ifu_id: return ifu_data_r;
			default: return lsu_data_r;
		endcase
	endfunction

	function automatic data_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// expected word after a strobed write
	function automatic data_t apply_strobes(input data_t old_w, input data_t new_w,
		input strb_t st);
		data_t mask;
		for (int b = 0; b < 8; b++) begin
			mask[b*8 +: 8] = {8{st[b]}};
		end
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic int mem_slot(input int i);
		return (i * 37 + 5) % mem_words;
	endfunction

	task automatic drive_master(input int m, input logic v, input addr_t a, input data_t wd,
		input strb_t st, input logic we);
		case (m)
			dm_id: begin
				dm_req_valid <= v;
				dm_addr <= a;
				dm_data_w <= wd;
				dm_wstrb <= st;
				dm_wen <= we;
			end
			ifu_id: begin
				ifu_req_valid <= v;
				ifu_addr <= a;
				ifu_data_w <= wd;
				ifu_wstrb <= st;
				ifu_wen <= we;
			end
			default: begin
				lsu_req_valid <= v;
				lsu_addr <= a;
				lsu_data_w <= wd;
				lsu_wstrb <= st;
				lsu_wen <= we;
			end
		endcase
	endtask

	// one transfer, lat counts edges after the accept edge
	task automatic bus_txn(input int m, input addr_t a, input data_t wd, input strb_t st,
		input logic we, input bit expect_rsp, output data_t rd, output int lat);
		int edges;
		bit got;
		edges = 0;
		got = 1'b0;
		rd = '0;
		@(posedge clk);
		drive_master(m, 1'b1, a, wd, st, we);
		while (!got && edges < rsp_limit) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			if (rsp_of(m)) begin
				got = 1'b1;
				rd = rdata_of(m);
			end
		end
		// release on the edge that samples the response
		@(posedge clk);
		drive_master(m, 1'b0, '0, '0, '0, 1'b0);
		lat = edges - 1;
		if (!got && expect_rsp) begin
			report_failure($sformatf("%s got no response within %0d cycles for address 0x%h",
				master_name(m), rsp_limit, a));
		end else if (got && !expect_rsp) begin
			report_failure($sformatf("%s got a response for unmapped address 0x%h",
				master_name(m), a));
		end
	endtask

	task automatic bus_write(input int m, input addr_t a, input data_t wd, input strb_t st,
		output int lat);
		data_t rd;
		bus_txn(m, a, wd, st, 1'b1, 1'b1, rd, lat);
		check_data(rd, '0, $sformatf("%s_data_r on write", master_name(m)));
	endtask

	task automatic bus_read(input int m, input addr_t a, output data_t rd, output int lat);
		bus_txn(m, a, '0, '0, 1'b0, 1'b1, rd, lat);
	endtask

	task automatic snapshot_req();
		req_snap = req_cnt;
	endtask

	// target slave must have been requested, every other one stayed quiet
	task automatic check_req_counts(input int target);
		for (int k = 0; k < 5; k++) begin
			if (k == target) begin
				check_bit(req_cnt[k] > req_snap[k], 1'b1,
					$sformatf("%s_req_valid seen", slave_name[k]));
			end else begin
				check_data(data_t'(req_cnt[k] - req_snap[k]), '0,
					$sformatf("%s_req_valid cycles", slave_name[k]));
			end
		end
	endtask

	task automatic test_mem_rw();
		int lat;
		int idx;
		addr_t a;
		data_t wd;
		data_t rd;
		strb_t st;
		for (int i = 0; i < 8; i++) begin
			idx = mem_slot(i);
			a = `MEM_BASE + (addr_t'(idx) << 3);
			wd = rand64();
			bus_write(lsu_id, a, wd, 8'hFF, lat);
			mem_model[idx] = wd;
			check_data(data_t'(lat), data_t'(`MEM_WAIT_CYCLES + 1), "mem write latency");
		end
		// partial strobes on every other word
		for (int i = 0; i < 8; i += 2) begin
			idx = mem_slot(i);
			a = `MEM_BASE + (addr_t'(idx) << 3);
			wd = rand64();
			st = strb_t'($random(seed));
			bus_write(lsu_id, a, wd, st, lat);
			mem_model[idx] = apply_strobes(mem_model[idx], wd, st);
		end
		for (int i = 0; i < 8; i++) begin
			idx = mem_slot(i);
			a = `MEM_BASE + (addr_t'(idx) << 3);
			bus_read(ifu_id, a, rd, lat);
			check_data(rd, mem_model[idx], "ifu_data_r from mem");
			check_data(data_t'(lat), data_t'(`MEM_WAIT_CYCLES + 1), "mem read latency");
			bus_read(dm_id, a, rd, lat);
			check_data(rd, mem_model[idx], "dm_data_r from mem");
			check_data(data_t'(lat), data_t'(`MEM_WAIT_CYCLES + 1), "mem read latency");
		end
	endtask

	task automatic test_decode();
		int lat;
		data_t rd;
		addr_t a;
		a = `PLIC_BASE + 64'h0020_0004;
		snapshot_req();
		bus_read(lsu_id, a, rd, lat);
		check_addr(plic_seen, a, "plic_addr");
		check_data(rd, a ^ plic_key, "lsu_data_r from plic");
		check_req_counts(1);
		a = `SYSBUS_BASE + 64'h1234_5678;
		snapshot_req();
		bus_read(ifu_id, a, rd, lat);
		check_addr(sysbus_seen, a, "sysbus_addr");
		check_data(rd, a ^ sysbus_key, "ifu_data_r from sysbus");
		check_req_counts(2);
		a = `PERIP_BASE + 64'h0ABC_DEF0;
		snapshot_req();
		bus_read(dm_id, a, rd, lat);
		check_addr(perip_seen, a, "perip_addr");
		check_data(rd, a ^ perip_key, "dm_data_r from perip");
		check_req_counts(3);
	endtask

	// three masters start on the same edge
	task automatic test_priority();
		addr_t dm_a;
		addr_t ifu_a;
		addr_t lsu_a;
		data_t dm_rd;
		data_t ifu_rd;
		data_t lsu_rd;
		int dm_lat;
		int ifu_lat;
		int lsu_lat;
		int dm_order;
		int ifu_order;
		int lsu_order;
		dm_a = `MEM_BASE + (addr_t'(mem_slot(3)) << 3);
		ifu_a = `PLIC_BASE + 64'h0000_1000;
		lsu_a = `PERIP_BASE + 64'h0000_0040;
		done_cnt = 0;
		fork
			begin
				bus_read(dm_id, dm_a, dm_rd, dm_lat);
				dm_order = done_cnt;
				done_cnt++;
			end
			begin
				bus_read(ifu_id, ifu_a, ifu_rd, ifu_lat);
				ifu_order = done_cnt;
				done_cnt++;
			end
			begin
				bus_read(lsu_id, lsu_a, lsu_rd, lsu_lat);
				lsu_order = done_cnt;
				done_cnt++;
			end
		join
		check_data(data_t'(dm_order), 64'd0, "dm completion order");
		check_data(data_t'(ifu_order), 64'd1, "ifu completion order");
		check_data(data_t'(lsu_order), 64'd2, "lsu completion order");
		// dm wins at once, so its memory latency is undisturbed
		check_data(data_t'(dm_lat), data_t'(`MEM_WAIT_CYCLES + 1), "dm mem latency");
		check_data(dm_rd, mem_model[mem_slot(3)], "dm_data_r under contention");
		check_data(ifu_rd, ifu_a ^ plic_key, "ifu_data_r under contention");
		check_data(lsu_rd, lsu_a ^ perip_key, "lsu_data_r under contention");
	endtask

	task automatic test_clint_regs();
		int lat;
		data_t rd;
		data_t wd;
		data_t t1;
		data_t t2;
		@(negedge clk);
		check_bit(msip_irq, 1'b0, "msip_irq after reset");
		check_bit(mtip_irq, 1'b0, "mtip_irq after reset");
		bus_write(dm_id, `CLINT_BASE + `CLINT_MSIP_OFS, 64'd1, 8'h01, lat);
		@(negedge clk);
		check_bit(msip_irq, 1'b1, "msip_irq after set");
		bus_write(dm_id, `CLINT_BASE + `CLINT_MSIP_OFS, 64'd0, 8'h01, lat);
		@(negedge clk);
		check_bit(msip_irq, 1'b0, "msip_irq after clear");
		// top bit set keeps mtimecmp above mtime
		wd = rand64() | 64'h8000_0000_0000_0000;
		bus_write(lsu_id, `CLINT_BASE + `CLINT_MTIMECMP_OFS, wd, 8'hFF, lat);
		bus_read(ifu_id, `CLINT_BASE + `CLINT_MTIMECMP_OFS, rd, lat);
		check_data(rd, wd, "mtimecmp readback");
		bus_read(lsu_id, `CLINT_BASE + `CLINT_MTIME_OFS, t1, lat);
		bus_read(lsu_id, `CLINT_BASE + `CLINT_MTIME_OFS, t2, lat);
		check_bit(t2 >= t1, 1'b1, "mtime not decreasing");
		wd = 64'h0000_0100_0000_0000;
		bus_write(dm_id, `CLINT_BASE + `CLINT_MTIME_OFS, wd, 8'hFF, lat);
		bus_read(dm_id, `CLINT_BASE + `CLINT_MTIME_OFS, rd, lat);
		check_bit(rd >= wd, 1'b1, "mtime at least the written value");
	endtask

	task automatic test_timer_irq();
		int lat;
		int cycles;
		int irq_limit;
		irq_limit = 10 * `MTIME_TICK_DIV + 8;
		// mtime first so mtip stays low in between
		bus_write(lsu_id, `CLINT_BASE + `CLINT_MTIME_OFS, 64'd0, 8'hFF, lat);
		bus_write(lsu_id, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 64'd10, 8'hFF, lat);
		cycles = 0;
		@(negedge clk);
		// mtime restarted from zero, still far below 10
		check_bit(mtip_irq, 1'b0, "mtip_irq before mtime reaches mtimecmp");
		while (!mtip_irq && cycles < irq_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!mtip_irq) begin
			report_failure($sformatf("mtip_irq did not rise within %0d cycles", irq_limit));
		end
		bus_write(lsu_id, `CLINT_BASE + `CLINT_MTIMECMP_OFS, '1, 8'hFF, lat);
		@(negedge clk);
		check_bit(mtip_irq, 1'b0, "mtip_irq after mtimecmp all ones");
	endtask

	task automatic test_unmapped();
		int lat;
		data_t rd;
		snapshot_req();
		bus_txn(lsu_id, 64'h0000_0000_1000_0000, '0, '0, 1'b0, 1'b0, rd, lat);
		check_req_counts(-1);
		// nonzero upper half never decodes
		snapshot_req();
		bus_txn(ifu_id, 64'h0000_0001_8000_0000, '0, '0, 1'b0, 1'b0, rd, lat);
		check_req_counts(-1);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		dm_req_valid = 1'b0;
		dm_addr = '0;
		dm_data_w = '0;
		dm_wstrb = '0;
		dm_wen = 1'b0;
		ifu_req_valid = 1'b0;
		ifu_addr = '0;
		ifu_data_w = '0;
		ifu_wstrb = '0;
		ifu_wen = 1'b0;
		lsu_req_valid = 1'b0;
		lsu_addr = '0;
		lsu_data_w = '0;
		lsu_wstrb = '0;
		lsu_wen = 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		test_mem_rw();
		test_decode();
		test_priority();
		test_clint_regs();
		test_timer_irq();
		test_unmapped();
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
		if (mismatch_cnt == 0 && failure_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/innerbus_pkg.sv
design/innerbus_crossbar.sv
design/clint_mtime.sv
design/clint.sv
design/mem_ctrl_fsm.sv
design/mem_array.sv
design/innerbus_top.sv
tests/innerbus_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the inner bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module innerbus_tb -f src.f

./obj_dir/Vinnerbus_tb > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
